/* verilog/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  localparam word_t RESET_PC = 32'h8000_0000;  // first fetch address

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  // load/store width codes
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  localparam logic [2:0] F3_ADDI = 3'b000;  // only OP-IMM variant kept
  localparam logic [2:0] F3_PRIV = 3'b000;  // ecall/ebreak group

  typedef enum logic [1:0] {
    IMM_I = 2'd0,
    IMM_S = 2'd1,
    IMM_J = 2'd2,
    IMM_U = 2'd3
  } imm_sel_e;

  typedef enum logic {
    OPA_RS1 = 1'b0,
    OPA_PC  = 1'b1
  } op_a_sel_e;

  typedef enum logic [1:0] {
    WB_ADD  = 2'd0,  // adder result
    WB_PC4  = 2'd1,  // link address
    WB_LOAD = 2'd2
  } wb_sel_e;

  typedef struct packed {
    logic      reg_we;
    logic      mem_rd;
    logic      mem_wr;
    op_a_sel_e op_a_sel;
    imm_sel_e  imm_sel;
    wb_sel_e   wb_sel;
    logic      jump;  // next pc from adder
    logic      halt;
  } ctrl_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] wmask;  // one bit per byte lane
    logic       we;
  } dmem_req_t;

endpackage

/* verilog/reg_file.sv */
module reg_file (
  input  logic              clk,
  input  logic              we,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::word_t     wdata,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::reg_addr_t dbg_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  output rv_pkg::word_t     dbg_data
);

  rv_pkg::word_t regs [0:31];

  // x0 is never stored
  always_ff @(posedge clk) begin
    if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
  assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];  // end-of-test peek

  // a value written to a live register reads back on the next cycle
  a_wr_rd : assert property (
    @(posedge clk) (we && (waddr != '0)) |=>
      ((rs1_addr != $past(waddr)) || (rs1_data == $past(wdata)))
  );

endmodule

/* verilog/imm_gen.sv */
module imm_gen (
  input  rv_pkg::word_t    inst,
  input  rv_pkg::imm_sel_e imm_sel,
  output rv_pkg::word_t    imm
);

  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_j;
  rv_pkg::word_t imm_u;

  // sign always comes from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};  // lui/auipc upper part

  always_comb begin
    case (imm_sel)
      rv_pkg::IMM_S: begin
        imm = imm_s;
      end
      rv_pkg::IMM_J: begin
        imm = imm_j;
      end
      rv_pkg::IMM_U: begin
        imm = imm_u;
      end
      default: begin
        imm = imm_i;  // also covers jalr and loads
      end
    endcase
  end

endmodule

/* verilog/ctrl_decode.sv */
module ctrl_decode (
  input  logic          [6:0] opcode,
  input  logic          [2:0] funct3,
  input  logic                enable,
  output rv_pkg::ctrl_t       ctrl
);

  always_comb begin
    ctrl = '0;  // no-op bundle
    if (enable) begin
      case (opcode)
        rv_pkg::OPC_OP_IMM: begin
          if (funct3 == rv_pkg::F3_ADDI) begin
            ctrl.reg_we  = 1'b1;
            ctrl.imm_sel = rv_pkg::IMM_I;
            ctrl.wb_sel  = rv_pkg::WB_ADD;
          end
        end
        rv_pkg::OPC_LUI: begin
          ctrl.reg_we  = 1'b1;  // rs1 forced to x0 upstream
          ctrl.imm_sel = rv_pkg::IMM_U;
          ctrl.wb_sel  = rv_pkg::WB_ADD;
        end
        rv_pkg::OPC_AUIPC: begin
          ctrl.reg_we   = 1'b1;
          ctrl.op_a_sel = rv_pkg::OPA_PC;
          ctrl.imm_sel  = rv_pkg::IMM_U;
          ctrl.wb_sel   = rv_pkg::WB_ADD;
        end
        rv_pkg::OPC_JAL: begin
          ctrl.reg_we   = 1'b1;
          ctrl.op_a_sel = rv_pkg::OPA_PC;
          ctrl.imm_sel  = rv_pkg::IMM_J;
          ctrl.wb_sel   = rv_pkg::WB_PC4;
          ctrl.jump     = 1'b1;
        end
        rv_pkg::OPC_JALR: begin
          ctrl.reg_we  = 1'b1;
          ctrl.imm_sel = rv_pkg::IMM_I;
          ctrl.wb_sel  = rv_pkg::WB_PC4;
          ctrl.jump    = 1'b1;
        end
        rv_pkg::OPC_LOAD: begin
          ctrl.reg_we  = 1'b1;
          ctrl.mem_rd  = 1'b1;
          ctrl.imm_sel = rv_pkg::IMM_I;
          ctrl.wb_sel  = rv_pkg::WB_LOAD;
        end
        rv_pkg::OPC_STORE: begin
          ctrl.mem_wr  = 1'b1;
          ctrl.imm_sel = rv_pkg::IMM_S;
        end
        rv_pkg::OPC_SYSTEM: begin
          ctrl.halt = (funct3 == rv_pkg::F3_PRIV);  // ebreak
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* verilog/lsu_align.sv */
module lsu_align (
  input  logic                mem_rd,
  input  logic                mem_wr,
  input  logic          [2:0] funct3,
  input  logic          [1:0] addr_lo,
  input  rv_pkg::word_t       store_data,
  input  rv_pkg::word_t       load_raw,
  output logic          [3:0] wmask,
  output rv_pkg::word_t       wdata,
  output rv_pkg::word_t       load_data
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // store mask and lane-replicated data
  always_comb begin
    wmask = 4'b0000;
    wdata = store_data;
    case (funct3)
      rv_pkg::F3_B: begin
        wdata = {4{store_data[7:0]}};
        wmask = 4'b0001 << addr_lo;
      end
      rv_pkg::F3_H: begin
        wdata = {2{store_data[15:0]}};
        if (!addr_lo[0]) begin
          wmask = addr_lo[1] ? 4'b1100 : 4'b0011;
        end
      end
      rv_pkg::F3_W: begin
        if (addr_lo == 2'b00) begin
          wmask = 4'b1111;
        end
      end
      default: begin
      end
    endcase
    if (!mem_wr) begin
      wmask = 4'b0000;  // loads and other ops never write
    end
  end

  assign ld_byte = load_raw[{addr_lo, 3'b000} +: 8];
  assign ld_half = addr_lo[1] ? load_raw[31:16] : load_raw[15:0];

  always_comb begin
    load_data = '0;  // misaligned and unknown widths read as zero
    if (mem_rd) begin
      case (funct3)
        rv_pkg::F3_B: begin
          load_data = {{24{ld_byte[7]}}, ld_byte};
        end
        rv_pkg::F3_BU: begin
          load_data = {24'h00_0000, ld_byte};
        end
        rv_pkg::F3_H: begin
          if (!addr_lo[0]) begin
            load_data = {{16{ld_half[15]}}, ld_half};
          end
        end
        rv_pkg::F3_HU: begin
          if (!addr_lo[0]) begin
            load_data = {16'h0000, ld_half};
          end
        end
        rv_pkg::F3_W: begin
          if (addr_lo == 2'b00) begin
            load_data = load_raw;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* verilog/core_top.sv */
module core_top (
  input  logic              clk,
  input  logic              arst_n,
  output rv_pkg::word_t     imem_addr,
  input  rv_pkg::word_t     imem_rdata,
  output rv_pkg::dmem_req_t dmem_req,
  input  rv_pkg::word_t     dmem_rdata,
  output logic              halt,
  input  rv_pkg::reg_addr_t dbg_reg_addr,
  output rv_pkg::word_t     dbg_reg_data
);

  rv_pkg::word_t     pc_q;
  rv_pkg::word_t     pc_next;
  rv_pkg::word_t     pc_plus4;
  logic              rst_seen_q;
  logic              halted_q;
  logic              run;
  rv_pkg::ctrl_t     ctrl;
  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  rv_pkg::word_t     imm;
  rv_pkg::word_t     op_a;
  rv_pkg::word_t     sum;
  rv_pkg::word_t     load_data;
  rv_pkg::word_t     wb_data;
  rv_pkg::word_t     store_lane;
  logic [3:0]        wmask;

  assign run = rst_seen_q & ~halted_q;  // one idle cycle after reset release

  ctrl_decode ctrl_decode_i (
    .opcode (imem_rdata[6:0]),
    .funct3 (imem_rdata[14:12]),
    .enable (run),
    .ctrl   (ctrl)
  );

  // U format carries no rs1, so lui adds to x0
  assign rs1_addr = (ctrl.imm_sel == rv_pkg::IMM_U) ? '0 : imem_rdata[19:15];

  reg_file reg_file_i (
    .clk      (clk),
    .we       (ctrl.reg_we),
    .waddr    (imem_rdata[11:7]),
    .wdata    (wb_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (imem_rdata[24:20]),
    .dbg_addr (dbg_reg_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dbg_data (dbg_reg_data)
  );

  imm_gen imm_gen_i (
    .inst    (imem_rdata),
    .imm_sel (ctrl.imm_sel),
    .imm     (imm)
  );

  assign op_a     = (ctrl.op_a_sel == rv_pkg::OPA_PC) ? pc_q : rs1_data;
  assign sum      = op_a + imm;  // alu result, mem address and jump target
  assign pc_plus4 = pc_q + 32'd4;

  lsu_align lsu_align_i (
    .mem_rd     (ctrl.mem_rd),
    .mem_wr     (ctrl.mem_wr),
    .funct3     (imem_rdata[14:12]),
    .addr_lo    (sum[1:0]),
    .store_data (rs2_data),
    .load_raw   (dmem_rdata),
    .wmask      (wmask),
    .wdata      (store_lane),
    .load_data  (load_data)
  );

  assign dmem_req = '{addr: sum, wdata: store_lane, wmask: wmask, we: |wmask};

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::WB_PC4: begin
        wb_data = pc_plus4;
      end
      rv_pkg::WB_LOAD: begin
        wb_data = load_data;
      end
      default: begin
        wb_data = sum;
      end
    endcase
  end

  always_comb begin
    if (!run || ctrl.halt) begin
      pc_next = pc_q;  // hold
    end else if (ctrl.jump) begin
      pc_next = {sum[rv_pkg::XLEN-1:1], 1'b0};
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q       <= rv_pkg::RESET_PC;
      rst_seen_q <= 1'b0;
      halted_q   <= 1'b0;
    end else begin
      pc_q       <= pc_next;
      rst_seen_q <= 1'b1;
      if (ctrl.halt) begin
        halted_q <= 1'b1;  // sticky until reset
      end
    end
  end

  assign imem_addr = pc_q;
  assign halt      = halted_q | ctrl.halt;

  a_pc_aligned : assert property (
    @(posedge clk) disable iff (!arst_n) pc_q[1:0] == 2'b00
  );

endmodule

/* verif/tb_core.sv */
module tb_core;
  timeunit 1ns;
  timeprecision 1ps;

  logic              clk;
  logic              arst_n;
  rv_pkg::word_t     imem_addr;
  rv_pkg::word_t     imem_rdata;
  rv_pkg::dmem_req_t dmem_req;
  rv_pkg::word_t     dmem_rdata;
  logic              halt;
  rv_pkg::reg_addr_t dbg_reg_addr;
  rv_pkg::word_t     dbg_reg_data;

  rv_pkg::word_t     imem [rv_pkg::word_t];  // keyed by word address
  rv_pkg::word_t     dmem [rv_pkg::word_t];
  rv_pkg::dmem_req_t exp_stores [$];
  rv_pkg::reg_addr_t exp_reg_idx [$];
  rv_pkg::word_t     exp_reg_val [$];
  rv_pkg::word_t     exp_pc;
  int                n_inst;
  int                n_store;
  int                n_err;
  bit                golden_ok;
  bit                golden_done;

  core_top dut_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .imem_addr    (imem_addr),
    .imem_rdata   (imem_rdata),
    .dmem_req     (dmem_req),
    .dmem_rdata   (dmem_rdata),
    .halt         (halt),
    .dbg_reg_addr (dbg_reg_addr),
    .dbg_reg_data (dbg_reg_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  function automatic rv_pkg::word_t word_key(rv_pkg::word_t addr);
    return {addr[31:2], 2'b00};
  endfunction

  function automatic rv_pkg::word_t fetch_inst(rv_pkg::word_t addr);
    if (imem.exists(word_key(addr))) begin
      return imem[word_key(addr)];
    end
    return '0;  // opcode 0 decodes as a no-op
  endfunction

  function automatic rv_pkg::word_t read_data(rv_pkg::word_t addr);
    if (dmem.exists(word_key(addr))) begin
      return dmem[word_key(addr)];
    end
    return '0;
  endfunction

  task automatic write_data(rv_pkg::dmem_req_t req);
    rv_pkg::word_t word;
    word = read_data(req.addr);
    for (int i = 0; i < 4; i++) begin
      if (req.wmask[i]) begin
        word[8*i +: 8] = req.wdata[8*i +: 8];  // masked lanes only
      end
    end
    dmem[word_key(req.addr)] = word;
  endtask

  task automatic compare_word(string name, rv_pkg::word_t got, rv_pkg::word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: expected %h, got %h", name, exp, got);
      n_err++;
    end
  endtask

  task automatic read_golden();
    int                fd;
    int                code;
    logic [7:0]        tag;
    logic [1023:0]     skip;
    rv_pkg::word_t     a;
    rv_pkg::word_t     b;
    rv_pkg::word_t     c;
    rv_pkg::dmem_req_t st;
    fd = $fopen("verif/core_golden.txt", "r");
    if (fd == 0) begin
      $display("Golden file verif/core_golden.txt could not be opened");
      n_err++;
    end else begin
      golden_ok = 1'b1;
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tag);
        if (code != 1) begin
          break;
        end
        if (tag == "#") begin
          code = $fgets(skip, fd);  // column notes
        end else if (tag == "I") begin
          code = $fscanf(fd, "%h %h", a, b);
          imem[word_key(a)] = b;
          n_inst++;
        end else if (tag == "D") begin
          code = $fscanf(fd, "%h %h", a, b);
          dmem[word_key(a)] = b;
        end else if (tag == "S") begin
          code     = $fscanf(fd, "%h %h %h", a, b, c);
          st.addr  = a;
          st.wdata = b;
          st.wmask = c[3:0];
          st.we    = 1'b1;
          exp_stores.push_back(st);
        end else if (tag == "R") begin
          code = $fscanf(fd, "%h %h", a, b);
          exp_reg_idx.push_back(a[4:0]);
          exp_reg_val.push_back(b);
        end else if (tag == "P") begin
          code   = $fscanf(fd, "%h", a);
          exp_pc = a;
        end else begin
          $display("Golden file holds a line with an unknown tag");
          n_err++;
        end
      end
      $fclose(fd);
    end
    golden_done = 1'b1;
  endtask

  // instruction word first, then data once the address has settled
  always @(posedge clk) begin
    #1;
    imem_rdata = fetch_inst(imem_addr);
    #1;
    dmem_rdata = read_data(dmem_req.addr);
  end

  // mid-cycle store sampling, committed to the model right here
  always @(negedge clk) begin
    if (arst_n && dmem_req.we) begin
      if (n_store < exp_stores.size()) begin
        compare_word("dmem_req.addr", dmem_req.addr, exp_stores[n_store].addr);
        compare_word("dmem_req.wdata", dmem_req.wdata, exp_stores[n_store].wdata);
        compare_word("dmem_req.wmask", {28'h0, dmem_req.wmask},
                     {28'h0, exp_stores[n_store].wmask});
      end else begin
        $display("Unexpected store to address %h after the expected ones", dmem_req.addr);
        n_err++;
      end
      write_data(dmem_req);
      n_store++;
    end
  end

  task automatic run_program();
    repeat (15) @(posedge clk);
    @(negedge clk);
    compare_word("imem_addr", imem_addr, rv_pkg::RESET_PC);
    if (dmem_req.we !== 1'b0 || halt !== 1'b0) begin
      $display("Store enable or halt is active during reset");
      n_err++;
    end
    @(posedge clk);  // 16th reset cycle
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    while (halt !== 1'b1) begin
      @(negedge clk);
    end
    compare_word("imem_addr", imem_addr, exp_pc);
    repeat (4) begin
      @(negedge clk);
      compare_word("imem_addr", imem_addr, exp_pc);  // pc must hold
      if (halt !== 1'b1) begin
        $display("Halt dropped before reset");
        n_err++;
      end
    end
    if (n_store != exp_stores.size()) begin
      $display("Saw %0d stores but %0d were expected", n_store, exp_stores.size());
      n_err++;
    end
    foreach (exp_reg_idx[i]) begin
      @(posedge clk);
      #1;
      dbg_reg_addr = exp_reg_idx[i];
      @(negedge clk);
      compare_word($sformatf("dbg_reg_data[x%0d]", exp_reg_idx[i]), dbg_reg_data,
                   exp_reg_val[i]);
    end
  endtask

  task automatic report_and_finish();
    $display("Run complete: %0d errors, %0d of %0d stores seen", n_err, n_store,
             exp_stores.size());
    if (n_err == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  initial begin
    arst_n       = 1'b0;
    imem_rdata   = '0;
    dmem_rdata   = '0;
    dbg_reg_addr = '0;
    exp_pc       = '0;
    n_inst       = 0;
    n_store      = 0;
    n_err        = 0;
    golden_ok    = 1'b0;
    golden_done  = 1'b0;
    read_golden();
    if (golden_ok) begin
      run_program();
    end
    report_and_finish();
  end

  // watchdog, 40 ns per program word on top of the reset time
  initial begin
    wait (golden_done);
    #(40 * n_inst + 160);
    if (!halt) begin
      $display("Timeout: halt never came");
    end else begin
      $display("Timeout: register checks after halt did not complete");
    end
    n_err++;
    report_and_finish();
  end

endmodule

/* verif/core_golden.txt */
# I addr inst | D addr word | S addr wdata wmask, in store order
# R reg value | P final pc ; every field is hex
I 80000000 12300793
I 80000004 800010b7
I 80000008 ffb00113
I 8000000c 00001197
I 80000010 0000a203
I 80000014 00108283
I 80000018 0030c303
I 8000001c 00209383
I 80000020 0000d403
I 80000024 00008483
I 80000028 0020c503
I 8000002c 00009583
I 80000030 0020d603
I 80000034 0040a223
I 80000038 002082a3
I 8000003c 00809323
I 80000040 008092a3
I 80000044 0040a683
I 80000048 00179793
I 8000004c 0080076f
I 80000050 7ff00793
I 80000054 00d70867
I 80000058 45600793
I 8000005c 00100073
I 80000060 0040a023
D 80001000 8765f0a1
D 80001004 13579bdf
S 80001004 8765f0a1 f
S 80001005 fbfbfbfb 2
S 80001006 f0a1f0a1 c
R 00 00000000
R 01 80001000
R 02 fffffffb
R 03 8000100c
R 04 8765f0a1
R 05 fffffff0
R 06 00000087
R 07 ffff8765
R 08 0000f0a1
R 09 ffffffa1
R 0a 00000065
R 0b fffff0a1
R 0c 00008765
R 0d f0a1fba1
R 0e 80000050
R 0f 00000123
R 10 80000058
P 8000005c

/* vlog.f */
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/imm_gen.sv
verilog/ctrl_decode.sv
verilog/lsu_align.sv
verilog/core_top.sv
verif/tb_core.sv

/* Makefile */
TOP := tb_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
